// ==== dv/pixelStimulus.hex ====
// columns: mode sign value threshold inPair expectedPair
// pairs are pixel0 then pixel1, each pixel RRGGBB
// frame 0, brightness add 100
0 1 64 5a 001020304050 64748494a4b4
0 1 64 5a 9b9c9aff8001 fffffeffe465
0 1 64 5a 607090a0b0c0 c4d4f4ffffff
0 1 64 5a 112233445566 758697a8b9ca
0 1 64 5a 778899aabbcc dbecfdffffff
0 1 64 5a 010203fefdfc 656667ffffff
0 1 64 5a 123456789abc 7698badcfeff
0 1 64 5a 000000ffffff 646464ffffff
// frame 1, brightness subtract 100
0 0 64 5a 646563ff80c8 0001009b1c64
0 0 64 5a 001020a0b0c0 0000003c4c5c
0 0 64 5a 7090f0112233 0c2c8c000000
0 0 64 5a 778899aabbcc 132435465768
0 0 64 5a fefdfc010203 9a9998000000
0 0 64 5a 123456789abc 000000143658
0 0 64 5a 656667c8c9ca 010203646566
0 0 64 5a 000000ffffff 0000009b9b9b
// frame 2, invert on gray average
1 1 64 5a 000000ffffff ffffff000000
1 1 64 5a 306090ff0000 9f9f9faaaaaa
1 1 64 5a 010100010101 fffffffefefe
1 1 64 5a 808080102030 7f7f7fdfdfdf
1 1 64 5a fffffec86432 0101018b8b8b
1 1 64 5a 123456789abc cbcbcb656565
1 1 64 5a aabbcc050a0f 444444f5f5f5
1 1 64 5a 7f8081404041 7f7f7fbfbfbf
// frame 3, threshold at 90
2 1 64 5a 5a5a5a5b5b5b 000000ffffff
2 1 64 5a 5a5a5b5b5b5c 000000ffffff
2 1 64 5a ffffff000000 ffffff000000
2 1 64 5a ff0000ff1e00 000000ffffff
2 1 64 5a 10ff50304050 ffffff000000
2 1 64 5a b40064b45a00 ffffff000000
2 1 64 5a 5c5c5b595a5b ffffff000000
2 1 64 5a 808080202020 ffffff000000
// frame 4, contrast gain 2
3 1 64 5a 003f4080bfc0 00000080feff
3 1 64 5a ff417f81a010 ff027e82c000
3 1 64 5a 607090bec150 4060a0fcff20
3 1 64 5a 445566aabbcc 082a4cd4f6ff
3 1 64 5a 010203fefdfc 000000ffffff
3 1 64 5a 123456789abc 00002c70b4f8
3 1 64 5a 5058689098a8 203050a0b0d0
3 1 64 5a 4080bf3fc0ff 0080fe00ffff

// ==== dv/tbPixelFrame.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbPixelFrame;
	import pixelPkg::*;

	localparam int NUM_FRAMES      = 5;
	localparam int PAIRS_PER_FRAME = 8;
	localparam int NUM_PAIRS       = NUM_FRAMES * PAIRS_PER_FRAME;
	localparam int FIELDS          = 6;   // words per record in the data file
	localparam int STALL_LIMIT     = 200; // cycles without progress
	localparam int DRAIN_CYCLES    = 12;
	localparam int SEED            = 94060;

	logic       HCLK;
	logic       HRESETn;
	opMode_t    mode;
	logic       brightSign;
	channel_t   brightValue;
	channel_t   threshold;
	rgb_t       inPixel0;
	rgb_t       inPixel1;
	logic       inValid;
	logic       inReady;
	rgb_t       outPixel0;
	rgb_t       outPixel1;
	logic       outValid;
	logic       outReady;
	logic       frameDone;

	logic [47:0] stimMem [NUM_PAIRS * FIELDS]; // mode, sign, value, thresh, in, expected
	int          gapList [NUM_PAIRS];          // idle cycles before each input pair
	int          frameDoneCount [NUM_FRAMES];
	int          frameDoneTotal;
	int          checkCount;
	int          errorCount;
	int          timeoutCount;
	integer      seed;

	pixelFrameTop u_dut (
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.mode        (mode),
		.brightSign  (brightSign),
		.brightValue (brightValue),
		.threshold   (threshold),
		.inPixel0    (inPixel0),
		.inPixel1    (inPixel1),
		.inValid     (inValid),
		.inReady     (inReady),
		.outPixel0   (outPixel0),
		.outPixel1   (outPixel1),
		.outValid    (outValid),
		.outReady    (outReady),
		.frameDone   (frameDone)
	);

	initial begin
		HCLK = 1'b0;
		forever #4 HCLK = ~HCLK; // 8 ns period
	end

	task automatic checkValue(input logic [47:0] actual, input logic [47:0] expected,
			input string what);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// feeds all frames in order
	task automatic driveFrames();
		int  base;
		int  waitCnt;
		logic accepted;
		for (int f = 0; f < NUM_FRAMES && timeoutCount == 0; f++) begin
			waitCnt = 0;
			while (frameDoneTotal < f && timeoutCount == 0) begin // engine drained first
				@(posedge HCLK);
				waitCnt++;
				if (waitCnt > STALL_LIMIT) begin
					$display("ERROR at %0t ns: frame %0d never signalled completion",
						$time, f - 1);
					timeoutCount++;
				end
			end
			base = f * PAIRS_PER_FRAME * FIELDS;
			mode        <= opMode_t'(stimMem[base][1:0]);
			brightSign  <= stimMem[base + 1][0];
			brightValue <= stimMem[base + 2][7:0];
			threshold   <= stimMem[base + 3][7:0];
			for (int p = 0; p < PAIRS_PER_FRAME && timeoutCount == 0; p++) begin
				base = (f * PAIRS_PER_FRAME + p) * FIELDS;
				for (int g = 0; g < gapList[f * PAIRS_PER_FRAME + p]; g++) begin
					inValid <= 1'b0; // bubble
					@(posedge HCLK);
				end
				inValid  <= 1'b1;
				inPixel0 <= stimMem[base + 4][47:24];
				inPixel1 <= stimMem[base + 4][23:0];
				accepted = 1'b0;
				waitCnt  = 0;
				while (!accepted && timeoutCount == 0) begin
					@(posedge HCLK);
					if (inReady) begin
						accepted = 1'b1; // beat moved on this edge
					end else begin
						waitCnt++;
						if (waitCnt > STALL_LIMIT) begin
							$display("ERROR at %0t ns: input pair %0d was never accepted",
								$time, f * PAIRS_PER_FRAME + p);
							timeoutCount++;
						end
					end
				end
			end
			inValid <= 1'b0;
		end
	endtask

	// takes outputs under back-pressure and checks data and frame pulses
	task automatic monitorOutputs();
		int   idx;
		int   idle;
		logic take;
		logic expDone;
		logic fullSeen;
		idx      = 0;
		idle     = 0;
		fullSeen = 1'b0;
		while (idx < NUM_PAIRS && timeoutCount == 0) begin
			@(posedge HCLK);
			take    = outValid && outReady;
			expDone = take && ((idx % PAIRS_PER_FRAME) == PAIRS_PER_FRAME - 1);
			checkValue(48'(frameDone), 48'(expDone),
				$sformatf("frameDone near pair %0d", idx));
			if (inValid && !inReady) begin
				fullSeen = 1'b1; // stall reached the input stream
			end
			if (frameDone) begin
				frameDoneCount[idx / PAIRS_PER_FRAME]++;
				frameDoneTotal++;
			end
			if (take) begin
				checkValue({outPixel0, outPixel1}, stimMem[idx * FIELDS + 5],
					$sformatf("output pair %0d", idx));
				idx++;
				idle = 0;
			end else begin
				idle++;
				if (idle > STALL_LIMIT) begin
					if (fullSeen) begin
						$display("ERROR at %0t ns: no output after pair %0d, stream stalled",
							$time, idx);
					end else begin
						$display("ERROR at %0t ns: inReady never dropped with output stalled",
							$time);
					end
					timeoutCount++;
				end
			end
			if (fullSeen) begin
				outReady <= (($random(seed) & 3) != 0); // ready about 3 cycles in 4
			end else begin
				outReady <= 1'b0; // hold until intake, FIFO and output stage are full
			end
		end
	endtask

	initial begin
		HRESETn     = 1'b0;
		mode        = OP_BRIGHT;
		brightSign  = 1'b0;
		brightValue = '0;
		threshold   = '0;
		inPixel0    = '0;
		inPixel1    = '0;
		inValid     = 1'b0;
		outReady    = 1'b0;
		checkCount     = 0;
		errorCount     = 0;
		timeoutCount   = 0;
		frameDoneTotal = 0;
		seed           = SEED;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			frameDoneCount[f] = 0;
		end
		$readmemh("dv/pixelStimulus.hex", stimMem);
		for (int i = 0; i < NUM_PAIRS; i++) begin
			gapList[i] = $random(seed) & 3; // zero to three idle cycles
		end

		repeat (3) @(posedge HCLK);
		checkValue(48'(outValid), 48'd0, "outValid in reset");
		checkValue(48'(frameDone), 48'd0, "frameDone in reset");
		checkValue(48'(inReady), 48'd1, "inReady in reset");
		HRESETn <= 1'b1;
		@(posedge HCLK);
		checkValue(48'(outValid), 48'd0, "outValid after reset");

		fork
			driveFrames();
			monitorOutputs();
		join

		if (timeoutCount == 0) begin
			outReady <= 1'b1;
			repeat (DRAIN_CYCLES) begin
				@(posedge HCLK);
				checkValue(48'(outValid), 48'd0, "outValid after last pair"); // no duplicates
			end
			for (int f = 0; f < NUM_FRAMES; f++) begin
				checkValue(48'(frameDoneCount[f]), 48'd1,
					$sformatf("frameDone pulses, frame %0d", f));
			end
		end

		$display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule : tbPixelFrame

`default_nettype wire

// ==== rtl/pairFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module pairFifo #(
	parameter int FIFO_DEPTH = 4 // entries, power of two
) (
	input wire     HCLK,
	input wire     HRESETn,
	pixelBus.slave wr,
	pixelBus.slave rd
);
	import pixelPkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	typedef logic [PTR_W-1:0] ptr_t;  // wraps naturally at depth
	typedef logic [PTR_W:0]   count_t; // 0..FIFO_DEPTH

	pixelPair_t pairMem [FIFO_DEPTH]; // pair storage
	logic       lastMem [FIFO_DEPTH]; // end-of-frame flag per entry
	ptr_t       wrPtr;
	ptr_t       rdPtr;
	count_t     count;
	logic       full;
	logic       empty;
	logic       wrEn;
	logic       rdEn;

	assign full  = (count == count_t'(FIFO_DEPTH));
	assign empty = (count == '0);

	assign wrEn = wr.cyc && wr.stb && !full;  // write beat this cycle
	assign rdEn = rd.cyc && rd.stb && !empty; // read beat this cycle

	// acks are same-cycle, classic handshake
	assign wr.ack = wrEn;
	assign rd.ack = rdEn;

	assign rd.dat  = pairMem[rdPtr]; // head entry, valid when not empty
	assign rd.last = lastMem[rdPtr];

	always_ff @(posedge HCLK) begin
		if (wrEn) begin
			pairMem[wrPtr] <= wr.dat;
			lastMem[wrPtr] <= wr.last;
		end
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (wrEn) begin
				wrPtr <= wrPtr + ptr_t'(1);
			end
			if (rdEn) begin
				rdPtr <= rdPtr + ptr_t'(1);
			end
		end
	end

	// occupancy, written pair visible to the reader next cycle
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			count <= '0;
		end else begin
			case ({wrEn, rdEn})
				2'b10:   count <= count + count_t'(1); // push only
				2'b01:   count <= count - count_t'(1); // pop only
				default: count <= count;               // idle or both
			endcase
		end
	end

endmodule : pairFifo

`default_nettype wire

// ==== rtl/pixelBus.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pixelBus;
	import pixelPkg::*;

	logic cyc;              // bus cycle in progress
	logic stb;              // beat request
	wire  pixelPair_t dat;  // pair payload, driven by whichever side owns the data
	wire  last;             // last pair of frame, travels with dat
	logic ack;              // beat completes this cycle

	modport master (
		output cyc,
		output stb,
		inout  dat,
		inout  last,
		input  ack
	);

	modport slave (
		input  cyc,
		input  stb,
		inout  dat,
		inout  last,
		output ack
	);

endinterface : pixelBus

`default_nettype wire

// ==== rtl/pixelFrameTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixelFrameTop #(
	parameter int IMG_WIDTH  = 8, // pixels per line, even
	parameter int IMG_HEIGHT = 2, // lines per frame
	parameter int FIFO_DEPTH = 4  // buffered pairs, power of two
) (
	input  wire                     HCLK,
	input  wire                     HRESETn,
	input  wire pixelPkg::opMode_t  mode,
	input  wire                     brightSign,
	input  wire pixelPkg::channel_t brightValue,
	input  wire pixelPkg::channel_t threshold,
	input  wire pixelPkg::rgb_t     inPixel0,   // even pixel
	input  wire pixelPkg::rgb_t     inPixel1,   // odd pixel
	input  wire                     inValid,
	output logic                    inReady,
	output pixelPkg::rgb_t          outPixel0,
	output pixelPkg::rgb_t          outPixel1,
	output logic                    outValid,
	input  wire                     outReady,
	output logic                    frameDone
);
	import pixelPkg::*;

	pixelPair_t inPair;
	pixelPair_t outPair;

	assign inPair    = {inPixel0, inPixel1}; // even pixel on top
	assign outPixel0 = outPair[47:24];
	assign outPixel1 = outPair[23:0];

	pixelBus wrBus (); // intake to FIFO
	pixelBus rdBus (); // FIFO to operation unit

	pixelIntake #(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT)
	) u_intake (
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.inPair  (inPair),
		.inValid (inValid),
		.inReady (inReady),
		.wr      (wrBus.master)
	);

	pairFifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.wr      (wrBus.slave),
		.rd      (rdBus.slave)
	);

	pointOpUnit u_opUnit (
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.mode        (mode),
		.brightSign  (brightSign),
		.brightValue (brightValue),
		.threshold   (threshold),
		.outReady    (outReady),
		.rd          (rdBus.master),
		.outPair     (outPair),
		.outValid    (outValid),
		.frameDone   (frameDone)
	);

endmodule : pixelFrameTop

`default_nettype wire

// ==== rtl/pixelIntake.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixelIntake #(
	parameter int IMG_WIDTH  = 8, // pixels per line, even
	parameter int IMG_HEIGHT = 2  // lines per frame
) (
	input  wire                       HCLK,
	input  wire                       HRESETn,
	input  wire pixelPkg::pixelPair_t inPair,
	input  wire                       inValid,
	output logic                      inReady,
	pixelBus.master                   wr
);
	import pixelPkg::*;

	localparam int COL_W = $clog2(IMG_WIDTH);
	localparam int ROW_W = $clog2(IMG_HEIGHT + 1);

	typedef logic [COL_W-1:0] col_t;  // even pixel column of the pair
	typedef logic [ROW_W-1:0] row_t;  // raster line
	typedef enum logic {
		INTAKE_EMPTY,
		INTAKE_HOLD
	} intakeState_t;

	intakeState_t state;
	col_t         col;
	row_t         row;
	pixelPair_t   holdPair; // pair waiting for write ack
	logic         holdLast;
	logic         accept;
	logic         lineEnd;
	logic         frameEnd;

	assign lineEnd  = (col == col_t'(IMG_WIDTH - 2));             // last pair of a line
	assign frameEnd = lineEnd && (row == row_t'(IMG_HEIGHT - 1)); // last pair of frame

	// free slot, or the held pair leaves this cycle
	assign inReady = (state == INTAKE_EMPTY) || wr.ack;
	assign accept  = inValid && inReady;

	assign wr.cyc  = (state == INTAKE_HOLD); // held until ack
	assign wr.stb  = (state == INTAKE_HOLD);
	assign wr.dat  = holdPair;
	assign wr.last = holdLast;

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			state <= INTAKE_EMPTY;
		end else if (accept) begin
			state <= INTAKE_HOLD;  // refill, also on same-cycle ack
		end else if (wr.ack) begin
			state <= INTAKE_EMPTY; // drained, nothing new
		end
	end

	// raster position of the next accepted pair
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			col <= '0;
			row <= '0;
		end else if (accept) begin
			if (lineEnd) begin
				col <= '0;                               // wrap to line start
				row <= frameEnd ? '0 : row + row_t'(1);  // next line or new frame
			end else begin
				col <= col + col_t'(2);                  // two pixels per beat
			end
		end
	end

	always_ff @(posedge HCLK) begin
		if (accept) begin
			holdPair <= inPair;
			holdLast <= frameEnd; // tag end of frame
		end
	end

endmodule : pixelIntake

`default_nettype wire

// ==== rtl/pixelPkg.sv ====
`default_nettype none

package pixelPkg;

	typedef logic [7:0] channel_t;     // one color channel
	typedef logic [23:0] rgb_t;        // R in [23:16], G in [15:8], B in [7:0]
	typedef logic [47:0] pixelPair_t;  // even pixel on top, odd pixel below

	typedef logic [1:0] opMode_t;      // run-time operation select

	localparam opMode_t OP_BRIGHT   = 2'd0; // add or subtract brightValue
	localparam opMode_t OP_INVERT   = 2'd1; // 255 minus gray average
	localparam opMode_t OP_THRESH   = 2'd2; // binarize on gray average
	localparam opMode_t OP_CONTRAST = 2'd3; // fixed gain of 2 around mid gray

	localparam channel_t CHANNEL_MAX    = 8'd255; // saturation ceiling
	localparam channel_t CONTRAST_PIVOT = 8'd128; // mid gray

endpackage : pixelPkg

`default_nettype wire

// ==== rtl/pointOpUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pointOpUnit (
	input  wire                       HCLK,
	input  wire                       HRESETn,
	input  wire pixelPkg::opMode_t    mode,
	input  wire                       brightSign,  // 1 adds, 0 subtracts
	input  wire pixelPkg::channel_t   brightValue,
	input  wire pixelPkg::channel_t   threshold,
	input  wire                       outReady,
	pixelBus.master                   rd,
	output pixelPkg::pixelPair_t      outPair,
	output logic                      outValid,
	output logic                      frameDone
);
	import pixelPkg::*;

	typedef logic signed [10:0] wideChan_t; // channel result before clamping

	pixelPair_t resultPair;
	logic       outLast;  // registered end-of-frame flag
	logic       take;

	// clamp to 0..255
	function automatic channel_t clampChannel(input wideChan_t v);
		channel_t res;
		if (v < 0) begin
			res = '0;
		end else if (v > wideChan_t'(CHANNEL_MAX)) begin
			res = CHANNEL_MAX;
		end else begin
			res = v[7:0];
		end
		return res;
	endfunction

	function automatic rgb_t applyOp(input rgb_t px);
		logic [9:0] sum;
		channel_t   avg;
		channel_t   chan;
		wideChan_t  val;
		rgb_t       res;
		sum = 10'(px[23:16]) + 10'(px[15:8]) + 10'(px[7:0]); // R + G + B
		avg = channel_t'(sum / 10'd3);                        // gray, rounded down
		for (int i = 0; i < 3; i++) begin
			chan = px[8*i +: 8];
			val  = '0;
			case (mode)
				OP_BRIGHT: begin
					if (brightSign) begin
						val = wideChan_t'(chan) + wideChan_t'(brightValue);
					end else begin
						val = wideChan_t'(chan) - wideChan_t'(brightValue);
					end
				end
				OP_INVERT: val = wideChan_t'(CHANNEL_MAX) - wideChan_t'(avg); // same on all channels
				OP_THRESH: val = (avg > threshold) ? wideChan_t'(CHANNEL_MAX) : '0;
				OP_CONTRAST: begin
					val = (wideChan_t'(chan) <<< 1) - wideChan_t'(CONTRAST_PIVOT); // 2c - 128
				end
			endcase
			res[8*i +: 8] = clampChannel(val);
		end
		return res;
	endfunction

	// both pixels of the head pair
	always_comb begin
		resultPair = {applyOp(rd.dat[47:24]), applyOp(rd.dat[23:0])};
	end

	assign take = outValid && outReady; // output beat leaves

	// request while output register is free or draining
	assign rd.cyc = !outValid || outReady;
	assign rd.stb = !outValid || outReady;

	assign frameDone = take && outLast; // pulse on last pair of frame

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			outValid <= 1'b0;
			outLast  <= 1'b0;
		end else if (rd.ack) begin
			outValid <= 1'b1;     // new result next cycle
			outLast  <= rd.last;
		end else if (take) begin
			outValid <= 1'b0;     // emptied, nothing behind it
		end
	end

	always_ff @(posedge HCLK) begin
		if (rd.ack) begin
			outPair <= resultPair; // held until taken
		end
	end

endmodule : pointOpUnit

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the pixel engine testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tbPixelFrame -f tb.f

./obj_dir/VtbPixelFrame > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi

if ! grep -q "STATUS: PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

echo "simulation passed"

// ==== tb.f ====
rtl/pixelPkg.sv
rtl/pixelBus.sv
rtl/pixelIntake.sv
rtl/pairFifo.sv
rtl/pointOpUnit.sv
rtl/pixelFrameTop.sv
dv/tbPixelFrame.sv
